// File: flist.f
hdl/lms_pkg.sv
hdl/lms_rx_deinterleave.sv
hdl/lms_tx_interleave.sv
hdl/spi_fanout.sv
hdl/clock_ready_monitor.sv
hdl/lms_frontend_top.sv
test/tb_lms_frontend.sv

// File: hdl/clock_ready_monitor.sv
/*
   Restart pulse for the clock manager on any change of clock-ready.
   The pulse stays high while the HISTORY-bit sample history is mixed,
   which is HISTORY-1 cycles for an isolated change.
   Changes closer together than HISTORY cycles stretch the pulse.
   HISTORY must be at least 2.
*/
`timescale 1ns/1ps

module clock_ready_monitor
#(
   parameter int unsigned HISTORY = 6
)
(
   input  logic dsp_clk,
   input  logic arst_n_i,
   input  logic clock_ready_i,
   output logic pll_rst_o
);

   logic [HISTORY-1:0] hist_q;  // Newest sample in bit 0

   always_ff @(posedge dsp_clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
         hist_q <= '0;
      else
         hist_q <= {hist_q[HISTORY-2:0], clock_ready_i};
   end

   // Mixed ones and zeros means a recent change
   assign pll_rst_o = (|hist_q) & ~(&hist_q);

   // Pulse gone once the new level has filled the history
   a_pulse_length : assert property (
      @(posedge dsp_clk) disable iff (!arst_n_i)
      $rose(pll_rst_o) |-> ##(HISTORY-1) !pll_rst_o
   );

endmodule

// File: hdl/lms_frontend_top.sv
/*
   Sample path and SPI fan-out of the LMS6002D board front end.
   Everything runs on the rising edge of dsp_clk, no handshakes.
   Receive ports give one I/Q pair per strobe, transmit channels are
   interleaved with a shared IQ phase.
   SPI routing is combinational and expects at most one active select.
*/
`timescale 1ns/1ps

module lms_frontend_top
#(
   parameter int unsigned        NUM_CH    = 2,
   parameter int unsigned        NUM_SPI   = 9,
   parameter logic [NUM_SPI-1:0] MISO_MASK = 9'h16B,  // CLK, DAC, TX/RX DB, TX/RX ADC
   parameter int unsigned        HISTORY   = 6
)
(
   input  logic                                dsp_clk,
   input  logic                                arst_n_i,

   // Transceiver receive ports
   input  lms_pkg::lms_rx_bus_t                rx1_i,
   input  lms_pkg::lms_rx_bus_t                rx2_i,
   output lms_pkg::adc_iq_t                    adc1_o,
   output logic                                adc1_stb_o,
   output lms_pkg::adc_iq_t                    adc2_o,
   output logic                                adc2_stb_o,

   // Transmit channels
   input  lms_pkg::dac_iq_t     [NUM_CH-1:0]  dac_i,
   output lms_pkg::lms_tx_bus_t [NUM_CH-1:0]  tx_o,

   // Shared SPI master
   input  lms_pkg::spi_master_t                spi_i,
   input  logic                 [NUM_SPI-1:0] sen_n_i,
   input  logic                 [NUM_SPI-1:0] miso_i,
   output lms_pkg::spi_master_t [NUM_SPI-1:0] spi_o,
   output logic                                miso_o,

   // Clock manager
   input  logic                                clock_ready_i,
   output logic                                pll_rst_o
);

   lms_rx_deinterleave u_rx1
   (
      .dsp_clk      (dsp_clk),
      .arst_n_i     (arst_n_i),
      .rx_i         (rx1_i),
      .sample_o     (adc1_o),
      .sample_stb_o (adc1_stb_o)
   );

   lms_rx_deinterleave u_rx2
   (
      .dsp_clk      (dsp_clk),
      .arst_n_i     (arst_n_i),
      .rx_i         (rx2_i),
      .sample_o     (adc2_o),
      .sample_stb_o (adc2_stb_o)
   );

   lms_tx_interleave
   #(
      .NUM_CH (NUM_CH)
   )
   u_tx
   (
      .dsp_clk  (dsp_clk),
      .arst_n_i (arst_n_i),
      .dac_i    (dac_i),
      .tx_o     (tx_o)
   );

   spi_fanout
   #(
      .NUM_SPI   (NUM_SPI),
      .MISO_MASK (MISO_MASK)
   )
   u_spi
   (
      .dsp_clk  (dsp_clk),
      .arst_n_i (arst_n_i),
      .spi_i    (spi_i),
      .sen_n_i  (sen_n_i),
      .miso_i   (miso_i),
      .spi_o    (spi_o),
      .miso_o   (miso_o)
   );

   clock_ready_monitor
   #(
      .HISTORY (HISTORY)
   )
   u_clkmon
   (
      .dsp_clk       (dsp_clk),
      .arst_n_i      (arst_n_i),
      .clock_ready_i (clock_ready_i),
      .pll_rst_o     (pll_rst_o)
   );

endmodule

// File: hdl/lms_pkg.sv
/*
   Shared widths and bus structs for the LMS6002D front end.
   Receive and transmit converter words are 12 bits wide; the core side
   uses 14-bit ADC samples and 16-bit DAC words.
   IQ-select encoding on both directions is 0 = I, 1 = Q.
*/
package lms_pkg;

   localparam int LMS_DATA_W    = 12;  // LMS converter bus
   localparam int CORE_SAMPLE_W = 14;  // Core ADC sample
   localparam int DAC_WORD_W    = 16;  // Core DAC word

   // One receive port as it comes off the transceiver
   typedef struct packed {
      logic                  en;
      logic                  iq_sel;
      logic [LMS_DATA_W-1:0] data;
   } lms_rx_bus_t;

   // One transmit port towards the transceiver
   typedef struct packed {
      logic                  iq_sel;
      logic [LMS_DATA_W-1:0] data;
   } lms_tx_bus_t;

   // De-interleaved sample pair for the core
   typedef struct packed {
      logic [CORE_SAMPLE_W-1:0] i;
      logic [CORE_SAMPLE_W-1:0] q;
   } adc_iq_t;

   // DAC channel pair from the core
   typedef struct packed {
      logic [DAC_WORD_W-1:0] i;
      logic [DAC_WORD_W-1:0] q;
   } dac_iq_t;

   // Shared serial master lines
   typedef struct packed {
      logic sclk;
      logic mosi;
   } spi_master_t;

endpackage

// File: hdl/lms_rx_deinterleave.sv
/*
   Splits one multiplexed LMS receive port into I/Q pairs.
   Words are captured only while the port enable is high.
   The pair strobe fires only for a Q word that follows an I word,
   so a lone Q or a repeated Q updates the Q field without a strobe.
   Samples are zero-extended, the 12-bit word sits in the low bits.
*/
`timescale 1ns/1ps

module lms_rx_deinterleave
(
   input  logic                 dsp_clk,
   input  logic                 arst_n_i,
   input  lms_pkg::lms_rx_bus_t rx_i,
   output lms_pkg::adc_iq_t     sample_o,
   output logic                 sample_stb_o
);

   localparam int PAD_W = lms_pkg::CORE_SAMPLE_W - lms_pkg::LMS_DATA_W;

   lms_pkg::adc_iq_t                  sample_q;
   logic                              i_pending_q;  // I held, waiting for its Q
   logic                              stb_q;
   logic [lms_pkg::CORE_SAMPLE_W-1:0] word_ext;

   assign word_ext = {{PAD_W{1'b0}}, rx_i.data};

   always_ff @(posedge dsp_clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         sample_q    <= '0;
         i_pending_q <= 1'b0;
         stb_q       <= 1'b0;
      end
      else
      begin
         stb_q <= 1'b0;  // Single-cycle strobe
         if (rx_i.en)
         begin
            if (!rx_i.iq_sel)
            begin
               // I word, a second I simply replaces the first
               sample_q.i  <= word_ext;
               i_pending_q <= 1'b1;
            end
            else
            begin
               sample_q.q  <= word_ext;
               stb_q       <= i_pending_q;  // Pair complete
               i_pending_q <= 1'b0;
            end
         end
      end
   end

   assign sample_o     = sample_q;
   assign sample_stb_o = stb_q;

   // Every pair needs a fresh I, so two strobes in a row cannot happen
   a_stb_not_back_to_back : assert property (
      @(posedge dsp_clk) disable iff (!arst_n_i)
      sample_stb_o |=> !sample_stb_o
   );

endmodule

// File: hdl/lms_tx_interleave.sv
/*
   Time-multiplexes the core DAC channels onto the LMS transmit buses.
   A free-running phase bit alternates I (phase 0) and Q (phase 1),
   and all channels share it so their IQ alignment is identical.
   Only the low 12 bits of each 16-bit DAC word reach the transceiver.
   The transceiver's transmit enable is not looked at.
*/
`timescale 1ns/1ps

module lms_tx_interleave
#(
   parameter int unsigned NUM_CH = 2
)
(
   input  logic                                 dsp_clk,
   input  logic                                 arst_n_i,
   input  lms_pkg::dac_iq_t     [NUM_CH-1:0] dac_i,
   output lms_pkg::lms_tx_bus_t [NUM_CH-1:0] tx_o
);

   localparam int W = lms_pkg::LMS_DATA_W;

   logic                              phase_q;  // 0 = I slot, 1 = Q slot
   lms_pkg::lms_tx_bus_t [NUM_CH-1:0] tx_q;

   always_ff @(posedge dsp_clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
         phase_q <= 1'b0;
      else
         phase_q <= ~phase_q;
   end

   // Output registers, one word per channel per cycle
   always_ff @(posedge dsp_clk or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         tx_q <= '0;
      end
      else
      begin
         for (int ch = 0; ch < NUM_CH; ch++)
         begin
            tx_q[ch].iq_sel <= phase_q;
            if (phase_q)
               tx_q[ch].data <= dac_i[ch].q[W-1:0];
            else
               tx_q[ch].data <= dac_i[ch].i[W-1:0];
         end
      end
   end

   assign tx_o = tx_q;

   genvar g;
   generate
      for (g = 0; g < NUM_CH; g++)
      begin : g_chk
         // Flag on the bus trails the phase by exactly one edge
         a_iq_follows_phase : assert property (
            @(posedge dsp_clk) disable iff (!arst_n_i)
            tx_o[g].iq_sel == $past(phase_q)
         );
      end
   endgenerate

endmodule

// File: hdl/spi_fanout.sv
/*
   Fans one SPI master out to NUM_SPI peripherals with active-low selects.
   Purely combinational; clock and data are forced low at every
   peripheral that is not selected.
   MISO_MASK marks the peripherals that actually have a MISO line,
   unmasked inputs never reach miso_o.
   The clock and reset inputs serve only the select check.
*/
`timescale 1ns/1ps

module spi_fanout
#(
   parameter int unsigned        NUM_SPI   = 9,
   parameter logic [NUM_SPI-1:0] MISO_MASK = 9'h16B
)
(
   input  logic                                dsp_clk,
   input  logic                                arst_n_i,
   input  lms_pkg::spi_master_t                spi_i,
   input  logic                 [NUM_SPI-1:0] sen_n_i,
   input  logic                 [NUM_SPI-1:0] miso_i,
   output lms_pkg::spi_master_t [NUM_SPI-1:0] spi_o,
   output logic                                miso_o
);

   logic [NUM_SPI-1:0] sel;
   logic [NUM_SPI-1:0] miso_live;

   assign sel = ~sen_n_i;  // Active-high selects

   always_comb
   begin
      for (int p = 0; p < NUM_SPI; p++)
      begin
         if (sel[p])
            spi_o[p] = spi_i;
         else
            spi_o[p] = '0;  // Idle low when deselected
      end
   end

   // Selected and wired peripherals only
   assign miso_live = sel & miso_i & MISO_MASK;
   assign miso_o    = |miso_live;

   // The core's master talks to one peripheral at a time
   a_single_select : assert property (
      @(posedge dsp_clk) disable iff (!arst_n_i)
      $onehot0(sel)
   );

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the LMS front-end testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
   --top-module tb_lms_frontend \
   -f flist.f \
   -o sim_tb

# The log decides the result, so a simulator error exit is not fatal here
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "^Simulation finished: PASS$" sim.log; then
   echo "run_sim: passed"
   exit 0
else
   echo "run_sim: failed"
   exit 1
fi

// File: test/tb_lms_frontend.sv
/*
   Random-stimulus testbench for the LMS front end.
   Inputs change on the falling edge and outputs are checked there too,
   against a cycle model built from the receive, transmit, SPI and
   restart-pulse timing rules.
   Select patterns are one-hot or empty only, and clock-ready changes
   are spaced more than HISTORY cycles apart.
*/
`timescale 1ns/1ps

module tb_lms_frontend;

   localparam int unsigned        NUM_CH    = 2;
   localparam int unsigned        NUM_SPI   = 9;
   localparam logic [NUM_SPI-1:0] MISO_MASK = 9'h16B;
   localparam int unsigned        HISTORY   = 6;
   localparam int RESET_CYC   = 4;
   localparam int ALT_CYC     = 1000;  // Strict I/Q alternation first
   localparam int TEST_CYC    = 3000;
   localparam int TOTAL_CYC   = RESET_CYC + TEST_CYC;
   localparam int WATCHDOG_NS = 2 * TOTAL_CYC * 10;

   logic                                dsp_clk;
   logic                                arst_n_i;
   lms_pkg::lms_rx_bus_t                rx1_i;
   lms_pkg::lms_rx_bus_t                rx2_i;
   lms_pkg::adc_iq_t                    adc1_o;
   lms_pkg::adc_iq_t                    adc2_o;
   logic                                adc1_stb_o;
   logic                                adc2_stb_o;
   lms_pkg::dac_iq_t     [NUM_CH-1:0]  dac_i;
   lms_pkg::lms_tx_bus_t [NUM_CH-1:0]  tx_o;
   lms_pkg::spi_master_t                spi_i;
   logic                 [NUM_SPI-1:0] sen_n_i;
   logic                 [NUM_SPI-1:0] miso_i;
   lms_pkg::spi_master_t [NUM_SPI-1:0] spi_o;
   logic                                miso_o;
   logic                                clock_ready_i;
   logic                                pll_rst_o;

   // Model state
   lms_pkg::adc_iq_t                    exp_adc [2];
   logic                                exp_stb [2];
   logic                                i_waiting [2];
   lms_pkg::lms_tx_bus_t [NUM_CH-1:0]  exp_tx;
   logic                                exp_phase;
   logic                                ready_seen;   // Level taken at the last edge
   int                                  pulse_left;
   int                                  cur_sel;      // NUM_SPI means no select
   logic                                alt_iq;
   int                                  ready_gap;
   logic [31:0]                         lcg_state;
   int                                  rx_errs;
   int                                  tx_errs;
   int                                  spi_errs;
   int                                  clk_errs;
   int                                  misc_errs;
   int                                  pairs_seen;
   int                                  pulse_cycles;

   lms_frontend_top
   #(
      .NUM_CH    (NUM_CH),
      .NUM_SPI   (NUM_SPI),
      .MISO_MASK (MISO_MASK),
      .HISTORY   (HISTORY)
   )
   u_dut
   (
      .dsp_clk       (dsp_clk),
      .arst_n_i      (arst_n_i),
      .rx1_i         (rx1_i),
      .rx2_i         (rx2_i),
      .adc1_o        (adc1_o),
      .adc1_stb_o    (adc1_stb_o),
      .adc2_o        (adc2_o),
      .adc2_stb_o    (adc2_stb_o),
      .dac_i         (dac_i),
      .tx_o          (tx_o),
      .spi_i         (spi_i),
      .sen_n_i       (sen_n_i),
      .miso_i        (miso_i),
      .spi_o         (spi_o),
      .miso_o        (miso_o),
      .clock_ready_i (clock_ready_i),
      .pll_rst_o     (pll_rst_o)
   );

   always #5 dsp_clk = ~dsp_clk;

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   task automatic check_val(input string name, input logic [31:0] exp,
                            input logic [31:0] act, inout int errs);
      if (exp !== act)
      begin
         $display("[FAIL] %s expected %h got %h at %0t", name, exp, act, $time);
         errs++;
      end
   endtask

   // Model of one receive port for one edge
   task automatic model_rx(input int p, input lms_pkg::lms_rx_bus_t w);
      exp_stb[p] = 1'b0;
      if (w.en && !w.iq_sel)
      begin
         exp_adc[p].i = 14'(w.data);
         i_waiting[p] = 1'b1;
      end
      else if (w.en)
      begin
         exp_adc[p].q = 14'(w.data);
         exp_stb[p]   = i_waiting[p];  // Pair only after an I
         i_waiting[p] = 1'b0;
      end
   endtask

   // Applies the inputs that the last rising edge sampled
   task automatic update_model();
      model_rx(0, rx1_i);
      model_rx(1, rx2_i);
      for (int ch = 0; ch < NUM_CH; ch++)
      begin
         exp_tx[ch].iq_sel = exp_phase;
         exp_tx[ch].data   = exp_phase ? dac_i[ch].q[11:0] : dac_i[ch].i[11:0];
      end
      exp_phase = ~exp_phase;
      if (clock_ready_i != ready_seen)
         pulse_left = HISTORY - 1;
      else if (pulse_left > 0)
         pulse_left--;
      ready_seen = clock_ready_i;
   endtask

   task automatic check_outputs();
      lms_pkg::spi_master_t exp_spi;
      logic                 exp_miso;
      check_val("adc1_o.i", 32'(exp_adc[0].i), 32'(adc1_o.i), rx_errs);
      check_val("adc1_o.q", 32'(exp_adc[0].q), 32'(adc1_o.q), rx_errs);
      check_val("adc1_stb_o", 32'(exp_stb[0]), 32'(adc1_stb_o), rx_errs);
      check_val("adc2_o.i", 32'(exp_adc[1].i), 32'(adc2_o.i), rx_errs);
      check_val("adc2_o.q", 32'(exp_adc[1].q), 32'(adc2_o.q), rx_errs);
      check_val("adc2_stb_o", 32'(exp_stb[1]), 32'(adc2_stb_o), rx_errs);
      for (int ch = 0; ch < NUM_CH; ch++)
      begin
         check_val($sformatf("tx_o[%0d].iq_sel", ch), 32'(exp_tx[ch].iq_sel),
                   32'(tx_o[ch].iq_sel), tx_errs);
         check_val($sformatf("tx_o[%0d].data", ch), 32'(exp_tx[ch].data),
                   32'(tx_o[ch].data), tx_errs);
      end
      for (int p = 0; p < NUM_SPI; p++)
      begin
         exp_spi = (p == cur_sel) ? spi_i : '0;
         check_val($sformatf("spi_o[%0d]", p), 32'(exp_spi), 32'(spi_o[p]), spi_errs);
      end
      exp_miso = (cur_sel < NUM_SPI) && MISO_MASK[cur_sel] && miso_i[cur_sel];
      check_val("miso_o", 32'(exp_miso), 32'(miso_o), spi_errs);
      check_val("pll_rst_o", 32'(pulse_left != 0), 32'(pll_rst_o), clk_errs);
   endtask

   task automatic drive_inputs(input int cyc);
      logic [31:0] r;
      r = lcg_next();
      if (cyc < ALT_CYC)
      begin
         rx1_i.en     = 1'b1;
         rx1_i.iq_sel = alt_iq;
         rx2_i.en     = 1'b1;
         rx2_i.iq_sel = alt_iq;
         alt_iq       = ~alt_iq;
      end
      else
      begin
         // Gaps and repeated IQ-select values
         rx1_i.en     = (r[1:0] != 2'd0);
         rx1_i.iq_sel = r[2];
         rx2_i.en     = (r[4:3] != 2'd0);
         rx2_i.iq_sel = r[5];
      end
      rx1_i.data = r[17:6];
      rx2_i.data = r[29:18];
      for (int ch = 0; ch < NUM_CH; ch++)
      begin
         r = lcg_next();
         dac_i[ch].i = r[15:0];
         dac_i[ch].q = r[31:16];
      end
      r       = lcg_next();
      cur_sel = int'(r[31:16] % 16'd10);
      sen_n_i = (cur_sel < NUM_SPI) ? ~(NUM_SPI'(1) << cur_sel) : '1;
      spi_i   = r[1:0];
      miso_i  = r[10:2];
      r = lcg_next();
      ready_gap++;
      if (cyc >= RESET_CYC && ready_gap > HISTORY + 1 && r[3:0] == 4'd0)
      begin
         clock_ready_i = ~clock_ready_i;
         ready_gap     = 0;
      end
   endtask

   initial
   begin
      int total;
      dsp_clk       = 1'b0;
      arst_n_i      = 1'b0;
      rx1_i         = '0;
      rx2_i         = '0;
      dac_i         = '0;
      spi_i         = '0;
      sen_n_i       = '1;
      miso_i        = '0;
      clock_ready_i = 1'b0;
      exp_adc       = '{default: '0};
      exp_stb       = '{default: 1'b0};
      i_waiting     = '{default: 1'b0};
      exp_tx        = '0;
      exp_phase     = 1'b0;
      ready_seen    = 1'b0;
      pulse_left    = 0;
      cur_sel       = NUM_SPI;
      alt_iq        = 1'b0;
      ready_gap     = 0;
      lcg_state     = 32'h1f42;
      {rx_errs, tx_errs, spi_errs, clk_errs, misc_errs} = '0;
      pairs_seen    = 0;
      pulse_cycles  = 0;
      for (int cyc = 0; cyc < TOTAL_CYC; cyc++)
      begin
         @(negedge dsp_clk);
         if (arst_n_i)
            update_model();
         check_outputs();
         if (adc1_stb_o || adc2_stb_o)
            pairs_seen++;
         if (pll_rst_o)
            pulse_cycles++;
         if (cyc == RESET_CYC - 1)
            arst_n_i = 1'b1;  // Four rising edges in reset
         drive_inputs(cyc);
      end
      if (pairs_seen == 0)
      begin
         $display("No receive pair strobe was seen during the run");
         misc_errs++;
      end
      if (pulse_cycles == 0)
      begin
         $display("No restart pulse was seen during the run");
         misc_errs++;
      end
      total = rx_errs + tx_errs + spi_errs + clk_errs + misc_errs;
      $display("Errors: rx=%0d tx=%0d spi=%0d clk=%0d other=%0d total=%0d",
               rx_errs, tx_errs, spi_errs, clk_errs, misc_errs, total);
      if (total == 0)
         $display("Simulation finished: PASS");
      else
         $display("Simulation finished: FAIL");
      $finish;
   end

   initial
   begin
      #(WATCHDOG_NS);
      $display("Watchdog expired before the test loop completed");
      $display("Simulation finished: FAIL");
      $finish;
   end

endmodule
